//--- fu_config.svh
`ifndef FU_CONFIG_SVH
`define FU_CONFIG_SVH

// datapath width of the integer core
`define FU_XLEN 32

// instruction ID carried along with every request
`define FU_TID_WIDTH 8

// destination register index
`define FU_RD_WIDTH 5

// slots on the result-return bus: alu, csr, mul, div
`define FU_SLOT_N 4

`endif

//--- fu_pkg.sv
`default_nettype none
`include "fu_config.svh"

package fu_pkg;

	typedef logic [`FU_TID_WIDTH-1:0] tid_t;

	// encoding follows the issue stage, branch compares in the upper half
	typedef enum logic [3:0] {
		op_add  = 4'd0,
		op_sub  = 4'd1,
		op_sll  = 4'd2,
		op_slt  = 4'd3,
		op_sltu = 4'd4,
		op_xor  = 4'd5,
		op_srl  = 4'd6,
		op_sra  = 4'd7,
		op_or   = 4'd8,
		op_and  = 4'd9,
		op_beq  = 4'd10,
		op_bne  = 4'd11,
		op_blt  = 4'd12,
		op_bge  = 4'd13,
		op_bltu = 4'd14,
		op_bgeu = 4'd15
	} alu_op_t;

	typedef struct packed {
		alu_op_t op_mode;
		logic [`FU_XLEN-1:0] op1;
		logic [`FU_XLEN-1:0] op2;
		tid_t tid;
	} alu_req_t;

	// operands are sign or zero extended to 33 bits by the decoder
	typedef struct packed {
		logic [`FU_XLEN:0] op_a;
		logic [`FU_XLEN:0] op_b;
		logic sel; // mul: high word, div: remainder
		logic [`FU_RD_WIDTH-1:0] rd_id;
		tid_t inst_id;
	} muldiv_req_t;

	typedef struct packed {
		logic [`FU_XLEN-1:0] data;
		logic [`FU_RD_WIDTH-1:0] rd_id;
		tid_t inst_id;
	} unit_res_t;

	typedef struct packed {
		logic vld;
		tid_t tid;
		logic [`FU_XLEN-1:0] data;
	} fu_res_t;

	// positions on the result-return bus
	localparam int slot_alu = 0;
	localparam int slot_csr = 1;
	localparam int slot_mul = 2;
	localparam int slot_div = 3;

endpackage

`default_nettype wire

//--- fu_alu.sv
`default_nettype none
`include "fu_config.svh"

module fu_alu
	import fu_pkg::*;
(
	input wire alu_req_t req,
	output logic [`FU_XLEN-1:0] res,
	output logic brc_cond
);

	logic [`FU_XLEN-1:0] a;
	logic [`FU_XLEN-1:0] b;
	logic [4:0] shamt;
	logic eq; // shared by beq/bne
	logic lt_s; // shared by slt/blt/bge
	logic lt_u; // shared by sltu/bltu/bgeu

	assign a = req.op1;
	assign b = req.op2;
	assign shamt = req.op2[4:0]; // rv32i uses low 5 bits only

	assign eq = (a == b);
	assign lt_s = ($signed(a) < $signed(b));
	assign lt_u = (a < b);

	always_comb
	begin
		res = '0;
		brc_cond = 1'b0;
		case (req.op_mode)
			op_add:
				res = a + b;
			op_sub:
				res = a - b;
			op_sll:
				res = a << shamt;
			op_slt:
				res = {{(`FU_XLEN-1){1'b0}}, lt_s};
			op_sltu:
				res = {{(`FU_XLEN-1){1'b0}}, lt_u};
			op_xor:
				res = a ^ b;
			op_srl:
				res = a >> shamt;
			op_sra:
				res = $unsigned($signed(a) >>> shamt); // keeps sign bit
			op_or:
				res = a | b;
			op_and:
				res = a & b;
			op_beq:
				brc_cond = eq;
			op_bne:
				brc_cond = ~eq;
			op_blt:
				brc_cond = lt_s;
			op_bge:
				brc_cond = ~lt_s;
			op_bltu:
				brc_cond = lt_u;
			op_bgeu:
				brc_cond = ~lt_u;
			default:
			begin
				res = '0;
				brc_cond = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- fu_multiplier.sv
`default_nettype none
`include "fu_config.svh"

module fu_multiplier
	import fu_pkg::*;
(
	input wire aclk,
	input wire rst,
	input wire muldiv_req_t req,
	input wire req_valid,
	output logic req_ready,
	output unit_res_t res,
	output logic res_valid
);

	logic s1_vld;
	logic signed [`FU_XLEN:0] s1_a;
	logic signed [`FU_XLEN:0] s1_b;
	logic s1_sel;
	logic [`FU_RD_WIDTH-1:0] s1_rd_id;
	tid_t s1_inst_id;

	logic s2_vld;
	logic signed [2*`FU_XLEN+1:0] s2_prod; // full 66-bit product
	logic s2_sel;
	logic [`FU_RD_WIDTH-1:0] s2_rd_id;
	tid_t s2_inst_id;

	assign req_ready = 1'b1; // fully pipelined, never stalls

	always_ff @(posedge aclk)
	begin
		if (rst)
		begin
			s1_vld <= 1'b0;
			s2_vld <= 1'b0;
		end
		else
		begin
			s1_vld <= req_valid;
			s2_vld <= s1_vld;
		end
	end

	// operand and tag capture
	always_ff @(posedge aclk)
	begin
		if (req_valid)
		begin
			s1_a <= req.op_a;
			s1_b <= req.op_b;
			s1_sel <= req.sel;
			s1_rd_id <= req.rd_id;
			s1_inst_id <= req.inst_id;
		end
	end

	always_ff @(posedge aclk)
	begin
		if (s1_vld)
		begin
			s2_prod <= s1_a * s1_b;
			s2_sel <= s1_sel;
			s2_rd_id <= s1_rd_id;
			s2_inst_id <= s1_inst_id;
		end
	end

	assign res.data = s2_sel ? s2_prod[2*`FU_XLEN-1:`FU_XLEN] : s2_prod[`FU_XLEN-1:0];
	assign res.rd_id = s2_rd_id;
	assign res.inst_id = s2_inst_id;
	assign res_valid = s2_vld;

endmodule

`default_nettype wire

//--- fu_divider.sv
`default_nettype none
`include "fu_config.svh"

module fu_divider
	import fu_pkg::*;
(
	input wire aclk,
	input wire rst,
	input wire muldiv_req_t req,
	input wire req_valid,
	output logic req_ready,
	output unit_res_t res,
	output logic res_valid
);

	typedef enum logic [1:0] {
		st_idle,
		st_calc,
		st_done
	} div_state_t;

	div_state_t state;
	logic [5:0] cnt; // step counter, 33 steps

	logic [`FU_XLEN:0] rem_r; // partial remainder magnitude
	logic [`FU_XLEN:0] quo_r; // dividend shifts out, quotient shifts in
	logic [`FU_XLEN:0] dvs_r; // divisor magnitude
	logic [`FU_XLEN-1:0] dvd_r; // original dividend for the zero case
	logic neg_q;
	logic neg_r;
	logic dvs_zero;
	logic sel_r;
	logic [`FU_RD_WIDTH-1:0] rd_id_r;
	tid_t inst_id_r;

	logic accept;
	logic [`FU_XLEN+1:0] shift_rem;
	logic [`FU_XLEN+2:0] trial; // msb set means the subtract failed
	logic [`FU_XLEN:0] quo_fix;
	logic [`FU_XLEN:0] rem_fix;

	assign req_ready = (state == st_idle);
	assign accept = req_valid & req_ready;

	assign shift_rem = {rem_r, quo_r[`FU_XLEN]};
	assign trial = {1'b0, shift_rem} - {2'b00, dvs_r};

	always_ff @(posedge aclk)
	begin
		if (rst)
		begin
			state <= st_idle;
			cnt <= '0;
		end
		else
		begin
			case (state)
				st_idle:
					if (accept)
					begin
						state <= st_calc;
						cnt <= '0;
					end
				st_calc:
				begin
					cnt <= cnt + 6'd1;
					if (cnt == 6'd32)
						state <= st_done;
				end
				st_done:
					state <= st_idle; // one result cycle
				default:
					state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge aclk)
	begin
		if (accept)
		begin
			rem_r <= '0;
			quo_r <= req.op_a[`FU_XLEN] ? -req.op_a : req.op_a;
			dvs_r <= req.op_b[`FU_XLEN] ? -req.op_b : req.op_b;
			dvd_r <= req.op_a[`FU_XLEN-1:0];
			neg_q <= req.op_a[`FU_XLEN] ^ req.op_b[`FU_XLEN];
			neg_r <= req.op_a[`FU_XLEN]; // remainder follows dividend
			dvs_zero <= (req.op_b == '0);
			sel_r <= req.sel;
			rd_id_r <= req.rd_id;
			inst_id_r <= req.inst_id;
		end
		else if (state == st_calc)
		begin
			// restoring step
			if (trial[`FU_XLEN+2])
				rem_r <= shift_rem[`FU_XLEN:0];
			else
				rem_r <= trial[`FU_XLEN:0];
			quo_r <= {quo_r[`FU_XLEN-1:0], ~trial[`FU_XLEN+2]};
		end
	end

	assign quo_fix = neg_q ? -quo_r : quo_r;
	assign rem_fix = neg_r ? -rem_r : rem_r;

	always_comb
	begin
		if (dvs_zero)
			res.data = sel_r ? dvd_r : {`FU_XLEN{1'b1}}; // risc-v div by zero
		else
			res.data = sel_r ? rem_fix[`FU_XLEN-1:0] : quo_fix[`FU_XLEN-1:0];
	end

	assign res.rd_id = rd_id_r;
	assign res.inst_id = inst_id_r;
	assign res_valid = (state == st_done);

endmodule

`default_nettype wire

//--- fu_group.sv
`default_nettype none
`include "fu_config.svh"

module fu_group
	import fu_pkg::*;
(
	input wire aclk,
	input wire rst,

	// alu, always accepted
	input wire alu_req_t alu_req,
	input wire alu_valid,
	input wire alu_use_res, // result goes back to the register file
	output logic [`FU_XLEN-1:0] alu_res,
	output logic alu_brc_cond,

	// csr atomic read
	input wire [11:0] csr_addr,
	input wire tid_t csr_tid,
	input wire csr_valid,
	output logic [11:0] csr_raddr, // to external csr file
	input wire [`FU_XLEN-1:0] csr_dout, // old csr value

	// multiplier
	input wire muldiv_req_t mul_req,
	input wire mul_valid,
	output logic mul_ready,

	// divider
	input wire muldiv_req_t div_req,
	input wire div_valid,
	output logic div_ready,

	// result-return bus, one slot per unit
	output fu_res_t [`FU_SLOT_N-1:0] fu_res
);

	unit_res_t mul_res;
	logic mul_res_valid;
	unit_res_t div_res;
	logic div_res_valid;

	fu_alu fu_alu_inst (
		.req(alu_req),
		.res(alu_res),
		.brc_cond(alu_brc_cond)
	);

	fu_multiplier fu_multiplier_inst (
		.aclk(aclk),
		.rst(rst),
		.req(mul_req),
		.req_valid(mul_valid),
		.req_ready(mul_ready),
		.res(mul_res),
		.res_valid(mul_res_valid)
	);

	fu_divider fu_divider_inst (
		.aclk(aclk),
		.rst(rst),
		.req(div_req),
		.req_valid(div_valid),
		.req_ready(div_ready),
		.res(div_res),
		.res_valid(div_res_valid)
	);

	assign csr_raddr = csr_addr;

	// branches with no rd write nothing back
	assign fu_res[slot_alu] = '{vld: alu_valid & alu_use_res, tid: alu_req.tid, data: alu_res};
	assign fu_res[slot_csr] = '{vld: csr_valid, tid: csr_tid, data: csr_dout};
	assign fu_res[slot_mul] = '{vld: mul_res_valid, tid: mul_res.inst_id, data: mul_res.data};
	assign fu_res[slot_div] = '{vld: div_res_valid, tid: div_res.inst_id, data: div_res.data};

endmodule

`default_nettype wire

//--- tb_fu_group.sv
`default_nettype none
`include "fu_config.svh"

module tb_fu_group
	import fu_pkg::*;
;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int n_alu = 200;
	localparam int n_csr = 64;
	localparam int n_mul = 100;
	localparam int n_div = 64; // 60 random plus 4 corner cases
	localparam int n_other = n_alu + n_csr + n_mul + 10;
	localparam int watchdog_cycles = 2 * (40 * n_div + 10 * n_other);

	logic aclk;
	logic rst;
	alu_req_t alu_req;
	logic alu_valid;
	logic alu_use_res;
	logic [`FU_XLEN-1:0] alu_res;
	logic alu_brc_cond;
	logic [11:0] csr_addr;
	tid_t csr_tid;
	logic csr_valid;
	logic [11:0] csr_raddr;
	logic [`FU_XLEN-1:0] csr_dout;
	muldiv_req_t mul_req;
	logic mul_valid;
	logic mul_ready;
	muldiv_req_t div_req;
	logic div_valid;
	logic div_ready;
	fu_res_t [`FU_SLOT_N-1:0] fu_res;

	int cyc = 0;
	int mul_seen;
	int div_seen;
	logic div_busy;
	logic [32:0] exp_alu;
	logic [39:0] exp_res; // tid and data
	int acc_cyc;
	logic [39:0] mul_exp_q[$];
	int mul_acc_q[$];
	logic [39:0] div_exp_q[$];
	int div_acc_q[$];

	fu_group fu_group_inst (
		.aclk(aclk),
		.rst(rst),
		.alu_req(alu_req),
		.alu_valid(alu_valid),
		.alu_use_res(alu_use_res),
		.alu_res(alu_res),
		.alu_brc_cond(alu_brc_cond),
		.csr_addr(csr_addr),
		.csr_tid(csr_tid),
		.csr_valid(csr_valid),
		.csr_raddr(csr_raddr),
		.csr_dout(csr_dout),
		.mul_req(mul_req),
		.mul_valid(mul_valid),
		.mul_ready(mul_ready),
		.div_req(div_req),
		.div_valid(div_valid),
		.div_ready(div_ready),
		.fu_res(fu_res)
	);

	// csr file model, every address bit shows up in the value
	function automatic logic [31:0] csr_value(input logic [11:0] addr);
		return {addr ^ 12'h5a3, 8'hc6, ~addr};
	endfunction

	assign csr_dout = csr_value(csr_raddr);

	function automatic logic [32:0] ref_alu(input alu_req_t r);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] y;
		logic br;
		a = r.op1;
		b = r.op2;
		y = '0;
		br = 1'b0;
		case (r.op_mode)
			op_add: y = a + b;
			op_sub: y = a - b;
			op_sll: y = a << b[4:0];
			op_slt: y = {31'd0, $signed(a) < $signed(b)};
			op_sltu: y = {31'd0, a < b};
			op_xor: y = a ^ b;
			op_srl: y = a >> b[4:0];
			op_sra: y = $signed(a) >>> b[4:0];
			op_or: y = a | b;
			op_and: y = a & b;
			op_beq: br = (a == b);
			op_bne: br = (a != b);
			op_blt: br = $signed(a) < $signed(b);
			op_bge: br = $signed(a) >= $signed(b);
			op_bltu: br = a < b;
			op_bgeu: br = a >= b;
			default: br = 1'b0;
		endcase
		return {br, y};
	endfunction

	function automatic logic [31:0] ref_mul(input muldiv_req_t r);
		longint p; // low 64 product bits hold both words
		p = longint'($signed(r.op_a)) * longint'($signed(r.op_b));
		return r.sel ? p[63:32] : p[31:0];
	endfunction

	function automatic logic [31:0] ref_div(input muldiv_req_t r);
		longint sa;
		longint sb;
		longint q;
		longint rm;
		sa = longint'($signed(r.op_a));
		sb = longint'($signed(r.op_b));
		if (sb == 0)
			return r.sel ? r.op_a[31:0] : 32'hffff_ffff;
		q = sa / sb; // truncates toward zero
		rm = sa % sb; // sign of dividend
		return r.sel ? rm[31:0] : q[31:0];
	endfunction

	// signed operands are sign extended, unsigned ones zero extended
	function automatic muldiv_req_t make_req(input logic [31:0] a, input logic [31:0] b,
		input logic sa, input logic sb, input logic sel, input tid_t id);
		muldiv_req_t r;
		r.op_a = {sa & a[31], a};
		r.op_b = {sb & b[31], b};
		r.sel = sel;
		r.rd_id = 5'(id);
		r.inst_id = id;
		return r;
	endfunction

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string msg);
		if (got !== exp)
		begin
			$display("error at %0t: %s, got %h, expected %h", $time, msg, got, exp);
			$display("TEST RESULT: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	initial
	begin
		aclk = 1'b0;
		forever #4 aclk = ~aclk;
	end

	always @(posedge aclk)
		cyc <= cyc + 1;

	// compare process, samples mid-cycle where everything is settled
	always @(negedge aclk)
	begin
		if (!rst)
		begin
			exp_alu = ref_alu(alu_req);
			if (alu_valid)
			begin
				check_val(64'(alu_res), 64'(exp_alu[31:0]), "alu result");
				check_val(64'(alu_brc_cond), 64'(exp_alu[32]), "alu branch flag");
				check_val(64'(fu_res[slot_alu].tid), 64'(alu_req.tid), "slot 0 tid");
				check_val(64'(fu_res[slot_alu].data), 64'(exp_alu[31:0]), "slot 0 data");
			end
			check_val(64'(fu_res[slot_alu].vld), 64'(alu_valid & alu_use_res), "slot 0 vld");
			check_val(64'(csr_raddr), 64'(csr_addr), "csr read address");
			check_val(64'(fu_res[slot_csr].vld), 64'(csr_valid), "slot 1 vld");
			if (csr_valid)
			begin
				check_val(64'(fu_res[slot_csr].data), 64'(csr_value(csr_addr)), "slot 1 data");
				check_val(64'(fu_res[slot_csr].tid), 64'(csr_tid), "slot 1 tid");
			end

			if (fu_res[slot_mul].vld)
			begin
				if (mul_exp_q.size() == 0)
					report_failure("multiplier returned a result that nobody asked for");
				exp_res = mul_exp_q.pop_front();
				acc_cyc = mul_acc_q.pop_front();
				check_val(64'(fu_res[slot_mul].data), 64'(exp_res[31:0]), "slot 2 data");
				check_val(64'(fu_res[slot_mul].tid), 64'(exp_res[39:32]), "slot 2 tid");
				check_val(64'(cyc - acc_cyc), 64'd2, "slot 2 latency");
				mul_seen++;
			end
			if (mul_valid && mul_ready)
			begin
				mul_exp_q.push_back({mul_req.inst_id, ref_mul(mul_req)});
				mul_acc_q.push_back(cyc);
			end

			if (div_busy)
				check_val(64'(div_ready), 64'd0, "div_ready while busy");
			if (fu_res[slot_div].vld)
			begin
				if (div_exp_q.size() == 0)
					report_failure("divider returned a result that nobody asked for");
				exp_res = div_exp_q.pop_front();
				acc_cyc = div_acc_q.pop_front();
				check_val(64'(fu_res[slot_div].data), 64'(exp_res[31:0]), "slot 3 data");
				check_val(64'(fu_res[slot_div].tid), 64'(exp_res[39:32]), "slot 3 tid");
				check_val(64'(cyc - acc_cyc), 64'd34, "slot 3 latency");
				div_busy = 1'b0;
				div_seen++;
			end
			if (div_valid && div_ready)
			begin
				div_exp_q.push_back({div_req.inst_id, ref_div(div_req)});
				div_acc_q.push_back(cyc);
				div_busy = 1'b1;
			end
		end
	end

	task automatic run_alu();
		for (int i = 0; i < n_alu; i++)
		begin
			alu_req.op_mode = alu_op_t'(4'(i)); // walks all 16 opcodes
			alu_req.op1 = $urandom;
			alu_req.op2 = ($urandom_range(0, 3) == 0) ? alu_req.op1 : $urandom;
			alu_req.tid = tid_t'($urandom);
			alu_valid = ($urandom_range(0, 7) != 0);
			alu_use_res = 1'($urandom);
			@(posedge aclk);
			#1;
		end
		alu_valid = 1'b0;
	endtask

	task automatic run_csr();
		for (int i = 0; i < n_csr; i++)
		begin
			csr_addr = 12'($urandom);
			csr_tid = tid_t'($urandom);
			csr_valid = ($urandom_range(0, 3) != 0);
			@(posedge aclk);
			#1;
		end
		csr_valid = 1'b0;
	endtask

	task automatic run_mul();
		for (int i = 0; i < n_mul; i++)
		begin
			mul_req = make_req($urandom, $urandom, 1'($urandom), 1'($urandom), 1'($urandom),
				tid_t'(i));
			mul_valid = 1'b1;
			while (!mul_ready)
			begin
				@(posedge aclk);
				#1;
			end
			@(posedge aclk); // transfer edge
			#1;
		end
		mul_valid = 1'b0;
	endtask

	// request stays put while the divider is busy
	task automatic send_div(input muldiv_req_t r);
		div_req = r;
		div_valid = 1'b1;
		while (!div_ready)
		begin
			@(posedge aclk);
			#1;
		end
		@(posedge aclk);
		#1;
	endtask

	task automatic run_div();
		logic [31:0] b;
		for (int i = 0; i < n_div - 4; i++)
		begin
			b = ($urandom_range(0, 1) == 1) ? $urandom : 32'($urandom_range(1, 1000));
			send_div(make_req($urandom, b, 1'($urandom), 1'($urandom), 1'($urandom),
				tid_t'(i)));
		end
		send_div(make_req(32'hfedc_ba98, 32'h0, 1'b1, 1'b1, 1'b0, 8'hd0)); // div by zero
		send_div(make_req(32'hfedc_ba98, 32'h0, 1'b1, 1'b1, 1'b1, 8'hd1));
		send_div(make_req(32'h8000_0000, 32'hffff_ffff, 1'b1, 1'b1, 1'b0, 8'hd2)); // overflow
		send_div(make_req(32'h8000_0000, 32'hffff_ffff, 1'b1, 1'b1, 1'b1, 8'hd3));
		div_valid = 1'b0;
	endtask

	initial
	begin
		int seed_val;
		seed_val = $urandom(75212);
		mul_seen = 0;
		div_seen = 0;
		div_busy = 1'b0;
		rst = 1'b1;
		alu_req = '0;
		alu_valid = 1'b0;
		alu_use_res = 1'b0;
		csr_addr = '0;
		csr_tid = '0;
		csr_valid = 1'b0;
		mul_req = '0;
		mul_valid = 1'b1; // requests offered during reset must be dropped
		div_req = '0;
		div_valid = 1'b1;
		repeat (10) @(posedge aclk);
		#1;
		rst = 1'b0;
		mul_valid = 1'b0;
		div_valid = 1'b0;
		@(negedge aclk);
		check_val(64'(fu_res[slot_mul].vld), 64'd0, "slot 2 vld after reset");
		check_val(64'(fu_res[slot_div].vld), 64'd0, "slot 3 vld after reset");
		check_val(64'(div_ready), 64'd1, "div_ready after reset");
		@(posedge aclk);
		#1;
		run_alu();
		run_csr();
		run_mul();
		run_div();
		while (mul_seen < n_mul || div_seen < n_div)
			@(posedge aclk);
		$display("TEST RESULT: PASS");
		$finish;
	end

	initial
	begin
		repeat (watchdog_cycles) @(posedge aclk);
		report_failure("the run timed out before all results came back");
	end

endmodule

`default_nettype wire

//--- files.f
+incdir+.
fu_pkg.sv
fu_alu.sv
fu_multiplier.sv
fu_divider.sv
fu_group.sv
tb_fu_group.sv

//--- run_sim.sh
#!/bin/sh
# build and run the fu_group testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_fu_group -f files.f \
	-o sim_tb_fu_group > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/sim_tb_fu_group > sim.log 2>&1
sim_status=$?

if grep -q "TEST RESULT: FAIL" sim.log; then
	echo "simulation reported failure, see sim.log"
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status, see sim.log"
	exit 1
fi

echo "simulation passed"
exit 0
